// File: design/proc_ctrl_params.svh
// pipeline control constants
// widths, manager CSR numbers and the instruction encodings that decode matches
`ifndef PROC_CTRL_PARAMS_SVH
`define PROC_CTRL_PARAMS_SVH

// widths
`define XLEN   32
`define REG_AW 5
`define CSR_AW 12

// manager port CSRs
`define CSR_PROC2MNGR 12'h7c0
`define CSR_MNGR2PROC 12'hfc0

// major opcodes
`define OPC_OP     7'b0110011
`define OPC_LOAD   7'b0000011
`define OPC_STORE  7'b0100011
`define OPC_BRANCH 7'b1100011
`define OPC_SYSTEM 7'b1110011

// funct3 codes
`define F3_ADD_SUB 3'b000
`define F3_SLL     3'b001
`define F3_SLT     3'b010
`define F3_SLTU    3'b011
`define F3_XOR     3'b100
`define F3_SRL_SRA 3'b101
`define F3_OR      3'b110
`define F3_AND     3'b111
`define F3_LW      3'b010
`define F3_SW      3'b010
`define F3_BNE     3'b001
`define F3_CSRRW   3'b001
`define F3_CSRRS   3'b010

// funct7 codes
`define F7_BASE 7'b0000000
`define F7_ALT  7'b0100000

// fetch pc select
`define PC_SEL_PLUS4  2'd0
`define PC_SEL_BRANCH 2'd1

`endif

// File: design/proc_ctrl_pkg.sv
// pipeline control types
// vector typedefs, control encodings and the structs passed between blocks
`include "proc_ctrl_params.svh"

package proc_ctrl_pkg;

  typedef logic [`XLEN-1:0]   inst_t;
  typedef logic [`REG_AW-1:0] reg_addr_t;
  typedef logic [`CSR_AW-1:0] csr_addr_t;

  // alu operation, cp0/cp1 pass an operand straight through
  typedef enum logic [3:0] {
    alu_add  = 4'd0,
    alu_sub  = 4'd1,
    alu_and  = 4'd2,
    alu_or   = 4'd3,
    alu_xor  = 4'd4,
    alu_slt  = 4'd5,
    alu_sltu = 4'd6,
    alu_sra  = 4'd7,
    alu_srl  = 4'd8,
    alu_sll  = 4'd9,
    alu_cp0  = 4'd11,
    alu_cp1  = 4'd12
  } alu_fn_e;

  typedef enum logic [2:0] {imm_i = 3'd0, imm_s = 3'd1, imm_b = 3'd2} imm_type_e;

  // second operand source
  typedef enum logic [1:0] {op2_rf = 2'd0, op2_imm = 2'd1, op2_mngr = 2'd2} op2_sel_e;

  typedef enum logic [1:0] {dmem_none = 2'd0, dmem_load = 2'd1, dmem_store = 2'd2} dmem_type_e;

  typedef enum logic {wb_alu = 1'b0, wb_mem = 1'b1} wb_sel_e;

  // one row of the decode table
  typedef struct packed {
    logic       inst_val;
    logic       is_bne;
    logic       rs1_en;
    logic       rs2_en;
    imm_type_e  imm_type;
    op2_sel_e   op2_sel;
    alu_fn_e    alu_fn;
    dmem_type_e dmem_type;
    wb_sel_e    wb_sel;
    logic       rf_wen;
    logic       proc2mngr;
    logic       mngr2proc;
  } decode_ctrl_t;

  // destination of one in-flight instruction, seen by the hazard check
  typedef struct packed {
    logic      val;
    logic      wen;
    reg_addr_t waddr;
  } stage_dst_t;

  // everything the datapath needs from control
  typedef struct packed {
    logic       reg_en_f;
    logic       reg_en_d;
    logic       reg_en_x;
    logic       reg_en_m;
    logic       reg_en_w;
    logic [1:0] pc_sel_f;
    imm_type_e  imm_type_d;
    op2_sel_e   op2_sel_d;
    alu_fn_e    alu_fn_x;
    dmem_type_e dmem_type_x;
    wb_sel_e    wb_sel_m;
    reg_addr_t  rf_waddr_w;
    logic       rf_wen_w;
  } dpath_ctrl_t;

endpackage

// File: design/ctrl_decode.sv
// D stage decoder
// control table plus manager CSR detection, purely combinational
`timescale 1ns/1ps
`include "proc_ctrl_params.svh"

module ctrl_decode import proc_ctrl_pkg::*; (
  input  inst_t        inst_d,
  output decode_ctrl_t dec
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  csr_addr_t  csr;

  assign opcode = inst_d[6:0];
  assign funct3 = inst_d[14:12];
  assign funct7 = inst_d[31:25];
  assign csr    = inst_d[31:20];

  // builds a legal row, manager flags are filled in afterwards
  function automatic decode_ctrl_t row(
    input logic       bne,
    input logic       rs1,
    input logic       rs2,
    input imm_type_e  imm,
    input op2_sel_e   op2,
    input alu_fn_e    fn,
    input dmem_type_e dm,
    input wb_sel_e    wb,
    input logic       wen
  );
    decode_ctrl_t r;
    r           = '0;
    r.inst_val  = 1'b1;
    r.is_bne    = bne;
    r.rs1_en    = rs1;
    r.rs2_en    = rs2;
    r.imm_type  = imm;
    r.op2_sel   = op2;
    r.alu_fn    = fn;
    r.dmem_type = dm;
    r.wb_sel    = wb;
    r.rf_wen    = wen;
    return r;
  endfunction

  //--------------------------------------------------
  // control table
  //--------------------------------------------------
  always_comb begin
    // anything unmatched stays illegal with no writes
    dec = '0;
    case (opcode)
      `OPC_OP: begin
        case ({funct7, funct3})
          {`F7_BASE, `F3_ADD_SUB}: dec = row(0, 1, 1, imm_i, op2_rf, alu_add,  dmem_none, wb_alu, 1);
          {`F7_ALT,  `F3_ADD_SUB}: dec = row(0, 1, 1, imm_i, op2_rf, alu_sub,  dmem_none, wb_alu, 1);
          {`F7_BASE, `F3_AND}:     dec = row(0, 1, 1, imm_i, op2_rf, alu_and,  dmem_none, wb_alu, 1);
          {`F7_BASE, `F3_OR}:      dec = row(0, 1, 1, imm_i, op2_rf, alu_or,   dmem_none, wb_alu, 1);
          {`F7_BASE, `F3_XOR}:     dec = row(0, 1, 1, imm_i, op2_rf, alu_xor,  dmem_none, wb_alu, 1);
          {`F7_BASE, `F3_SLT}:     dec = row(0, 1, 1, imm_i, op2_rf, alu_slt,  dmem_none, wb_alu, 1);
          {`F7_BASE, `F3_SLTU}:    dec = row(0, 1, 1, imm_i, op2_rf, alu_sltu, dmem_none, wb_alu, 1);
          {`F7_ALT,  `F3_SRL_SRA}: dec = row(0, 1, 1, imm_i, op2_rf, alu_sra,  dmem_none, wb_alu, 1);
          {`F7_BASE, `F3_SRL_SRA}: dec = row(0, 1, 1, imm_i, op2_rf, alu_srl,  dmem_none, wb_alu, 1);
          {`F7_BASE, `F3_SLL}:     dec = row(0, 1, 1, imm_i, op2_rf, alu_sll,  dmem_none, wb_alu, 1);
          default:                 dec = '0;
        endcase
      end
      // address is rs1 plus immediate in both memory ops
      `OPC_LOAD:
        if (funct3 == `F3_LW) dec = row(0, 1, 0, imm_i, op2_imm, alu_add, dmem_load, wb_mem, 1);
      `OPC_STORE:
        if (funct3 == `F3_SW) dec = row(0, 1, 1, imm_s, op2_imm, alu_add, dmem_store, wb_alu, 0);
      // branch condition comes back from the datapath comparator
      `OPC_BRANCH:
        if (funct3 == `F3_BNE) dec = row(1, 1, 1, imm_b, op2_rf, alu_sub, dmem_none, wb_alu, 0);
      `OPC_SYSTEM: begin
        if (funct3 == `F3_CSRRS) begin
          // csrr copies manager data into rd
          dec           = row(0, 0, 0, imm_i, op2_mngr, alu_cp1, dmem_none, wb_alu, 1);
          dec.mngr2proc = (csr == `CSR_MNGR2PROC);
        end else if (funct3 == `F3_CSRRW) begin
          // csrw forwards rs1 toward the manager
          dec           = row(0, 1, 0, imm_i, op2_rf, alu_cp0, dmem_none, wb_alu, 0);
          dec.proc2mngr = (csr == `CSR_PROC2MNGR);
        end
      end
      default: dec = '0;
    endcase
  end

endmodule

// File: design/ctrl_hazard.sv
// read-after-write hazard detect
// stalls D while a source register is still being produced further down
`timescale 1ns/1ps

module ctrl_hazard import proc_ctrl_pkg::*; (
  input  inst_t        inst_d,
  input  decode_ctrl_t dec,
  input  stage_dst_t   dst_x,
  input  stage_dst_t   dst_m,
  input  stage_dst_t   dst_w,
  output logic         hazard_stall
);

  reg_addr_t rs1;
  reg_addr_t rs2;

  assign rs1 = inst_d[19:15];
  assign rs2 = inst_d[24:20];

  // one source against one destination, x0 never conflicts
  function automatic logic hit(input logic en, input reg_addr_t src, input stage_dst_t dst);
    return en && dst.val && dst.wen && (dst.waddr != '0) && (src == dst.waddr);
  endfunction

  logic rs1_busy;
  logic rs2_busy;

  // no bypass paths, so W counts too
  assign rs1_busy = hit(dec.rs1_en, rs1, dst_x) || hit(dec.rs1_en, rs1, dst_m)
                 || hit(dec.rs1_en, rs1, dst_w);
  assign rs2_busy = hit(dec.rs2_en, rs2, dst_x) || hit(dec.rs2_en, rs2, dst_m)
                 || hit(dec.rs2_en, rs2, dst_w);

  // D valid is qualified in the pipeline
  assign hazard_stall = rs1_busy || rs2_busy;

endmodule

// File: design/ctrl_pipeline.sv
// stage sequencing for the 5-stage pipe
// valid bits, stall and squash chain, X/M/W control registers and stream handshakes
`timescale 1ns/1ps
`include "proc_ctrl_params.svh"

module ctrl_pipeline import proc_ctrl_pkg::*; (
  input  logic         clk,
  input  logic         reset,
  input  decode_ctrl_t dec,
  input  logic         hazard_stall,
  output logic         imem_req_val,
  input  logic         imem_req_rdy,
  input  logic         imem_resp_val,
  output logic         imem_resp_rdy,
  output logic         imem_resp_drop,
  output logic         dmem_req_val,
  input  logic         dmem_req_rdy,
  input  logic         dmem_resp_val,
  output logic         dmem_resp_rdy,
  input  logic         mngr2proc_val,
  output logic         mngr2proc_rdy,
  output logic         proc2mngr_val,
  input  logic         proc2mngr_rdy,
  input  logic         br_cond_eq_x,
  output stage_dst_t   dst_x,
  output stage_dst_t   dst_m,
  output stage_dst_t   dst_w,
  output dpath_ctrl_t  ctrl,
  output logic         commit,
  input  reg_addr_t    rd_d
);

  logic val_f, val_d, val_x, val_m, val_w;
  // stall causes raised by each stage itself
  logic ostall_f, ostall_d, ostall_x, ostall_m, ostall_w;
  logic stall_f, stall_d, stall_x, stall_m, stall_w;
  logic osquash_x;
  logic squash_f, squash_d;
  logic next_val_f, next_val_d, next_val_x, next_val_m;

  // registered decode rows and destinations
  decode_ctrl_t ctl_x, ctl_m, ctl_w;
  reg_addr_t    waddr_x, waddr_m, waddr_w;

  //--------------------------------------------------
  // stall and squash chain
  //--------------------------------------------------
  assign ostall_f = val_f && !imem_resp_val;
  assign ostall_d = val_d && ((dec.mngr2proc && !mngr2proc_val) || hazard_stall);
  assign ostall_x = val_x && (ctl_x.dmem_type != dmem_none) && !dmem_req_rdy;
  assign ostall_m = val_m && (ctl_m.dmem_type != dmem_none) && !dmem_resp_val;
  assign ostall_w = val_w && ctl_w.proc2mngr && !proc2mngr_rdy;

  // a stage holds on its own cause or any cause ahead of it
  assign stall_w = val_w && ostall_w;
  assign stall_m = val_m && (ostall_m || ostall_w);
  assign stall_x = val_x && (ostall_x || ostall_m || ostall_w);
  assign stall_d = val_d && (ostall_d || ostall_x || ostall_m || ostall_w);
  assign stall_f = val_f && (ostall_f || ostall_d || ostall_x || ostall_m || ostall_w);

  // taken bne, only once X actually moves on
  assign osquash_x = val_x && !stall_x && ctl_x.is_bne && !br_cond_eq_x;
  assign squash_f  = val_f && osquash_x;
  assign squash_d  = val_d && osquash_x;

  //--------------------------------------------------
  // F stage
  //--------------------------------------------------
  // request goes out for the next pc, never during reset
  assign imem_req_val   = (!stall_f || squash_f) && !reset;
  assign imem_resp_rdy  = !stall_f || squash_f;
  assign imem_resp_drop = squash_f;

  // a refused request leaves a bubble in F
  always_ff @(posedge clk) begin
    if (reset) begin
      val_f <= 1'b0;
    end else if (ctrl.reg_en_f) begin
      val_f <= imem_req_rdy;
    end
  end

  assign next_val_f = val_f && !stall_f && !squash_f;

  //--------------------------------------------------
  // D stage
  //--------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      val_d <= 1'b0;
    end else if (ctrl.reg_en_d) begin
      val_d <= next_val_f;
    end
  end

  // manager data is taken only by a csrr that really leaves D
  assign mngr2proc_rdy = val_d && !stall_d && !squash_d && dec.mngr2proc;
  // illegal words turn into bubbles here
  assign next_val_d    = val_d && !stall_d && !squash_d && dec.inst_val;

  //--------------------------------------------------
  // X, M and W stages
  //--------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      val_x <= 1'b0;
      val_m <= 1'b0;
      val_w <= 1'b0;
    end else begin
      if (ctrl.reg_en_x) val_x <= next_val_d;
      if (ctrl.reg_en_m) val_m <= next_val_x;
      if (ctrl.reg_en_w) val_w <= next_val_m;
    end
  end

  // payload follows the same enables
  always_ff @(posedge clk) begin
    if (ctrl.reg_en_x) begin
      ctl_x   <= dec;
      waddr_x <= rd_d;
    end
    if (ctrl.reg_en_m) begin
      ctl_m   <= ctl_x;
      waddr_m <= waddr_x;
    end
    if (ctrl.reg_en_w) begin
      ctl_w   <= ctl_m;
      waddr_w <= waddr_m;
    end
  end

  assign next_val_x = val_x && !stall_x;
  assign next_val_m = val_m && !stall_m;

  // memory handshakes
  assign dmem_req_val  = val_x && !stall_x && (ctl_x.dmem_type != dmem_none);
  assign dmem_resp_rdy = val_m && !stall_m && (ctl_m.dmem_type != dmem_none);

  assign proc2mngr_val = val_w && !stall_w && ctl_w.proc2mngr;
  assign commit        = val_w && !stall_w;

  // destinations still in flight
  assign dst_x = '{val: val_x, wen: ctl_x.rf_wen, waddr: waddr_x};
  assign dst_m = '{val: val_m, wen: ctl_m.rf_wen, waddr: waddr_m};
  assign dst_w = '{val: val_w, wen: ctl_w.rf_wen, waddr: waddr_w};

  //--------------------------------------------------
  // datapath controls
  //--------------------------------------------------
  assign ctrl.reg_en_f    = !stall_f || squash_f;
  assign ctrl.reg_en_d    = !stall_d || squash_d;
  assign ctrl.reg_en_x    = !stall_x;
  assign ctrl.reg_en_m    = !stall_m;
  assign ctrl.reg_en_w    = !stall_w;
  assign ctrl.pc_sel_f    = osquash_x ? `PC_SEL_BRANCH : `PC_SEL_PLUS4;
  assign ctrl.imm_type_d  = dec.imm_type;
  assign ctrl.op2_sel_d   = dec.op2_sel;
  assign ctrl.alu_fn_x    = ctl_x.alu_fn;
  assign ctrl.dmem_type_x = ctl_x.dmem_type;
  assign ctrl.wb_sel_m    = ctl_m.wb_sel;
  assign ctrl.rf_waddr_w  = waddr_w;
  // a W write lands with the commit, whether or not W then holds for the manager
  assign ctrl.rf_wen_w    = val_w && ctl_w.rf_wen;

endmodule

// File: design/proc_ctrl_top.sv
// pipeline control unit
// decode, hazard check and stage sequencing for the 5-stage core
`timescale 1ns/1ps

module proc_ctrl_top import proc_ctrl_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  inst_t       inst_d,
  input  reg_addr_t   rd_d,
  input  logic        br_cond_eq_x,
  output logic        imem_req_val,
  input  logic        imem_req_rdy,
  input  logic        imem_resp_val,
  output logic        imem_resp_rdy,
  output logic        imem_resp_drop,
  output logic        dmem_req_val,
  input  logic        dmem_req_rdy,
  input  logic        dmem_resp_val,
  output logic        dmem_resp_rdy,
  input  logic        mngr2proc_val,
  output logic        mngr2proc_rdy,
  output logic        proc2mngr_val,
  input  logic        proc2mngr_rdy,
  output dpath_ctrl_t ctrl,
  output logic        commit
);

  decode_ctrl_t dec;
  logic         hazard_stall;
  stage_dst_t   dst_x, dst_m, dst_w;

  ctrl_decode u_decode (.inst_d(inst_d), .dec(dec));

  // destinations from the pipeline feed back into the hazard check
  ctrl_hazard u_hazard (
    .inst_d(inst_d), .dec(dec), .dst_x(dst_x), .dst_m(dst_m), .dst_w(dst_w),
    .hazard_stall(hazard_stall)
  );

  ctrl_pipeline u_pipeline (
    .clk(clk), .reset(reset), .dec(dec), .hazard_stall(hazard_stall),
    .imem_req_val(imem_req_val), .imem_req_rdy(imem_req_rdy),
    .imem_resp_val(imem_resp_val), .imem_resp_rdy(imem_resp_rdy),
    .imem_resp_drop(imem_resp_drop),
    .dmem_req_val(dmem_req_val), .dmem_req_rdy(dmem_req_rdy),
    .dmem_resp_val(dmem_resp_val), .dmem_resp_rdy(dmem_resp_rdy),
    .mngr2proc_val(mngr2proc_val), .mngr2proc_rdy(mngr2proc_rdy),
    .proc2mngr_val(proc2mngr_val), .proc2mngr_rdy(proc2mngr_rdy),
    .br_cond_eq_x(br_cond_eq_x),
    .dst_x(dst_x), .dst_m(dst_m), .dst_w(dst_w),
    .ctrl(ctrl), .commit(commit), .rd_d(rd_d)
  );

endmodule

// File: testbench/tb_clock_gen.sv
// testbench clock and reset source
// 20 ns clock, reset held for the first 10 rising edges
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // release just after an edge, like every other driven input
  initial begin
    reset = 1'b1;
    repeat (10) @(posedge clk);
    #2;
    reset = 1'b0;
  end

endmodule

// File: testbench/proc_ctrl_tb.sv
// pipeline control testbench
// imem, dmem and manager models around the control unit, checked against a program walk
`timescale 1ns/1ps
`include "proc_ctrl_params.svh"

module proc_ctrl_tb import proc_ctrl_pkg::*; ();

  localparam int MEM = 256;

  // field order is legal, wen, rs1_en, rs2_en, is_bne, mngr_rd, mngr_wr, dmem
  typedef struct packed {
    logic       legal;
    logic       wen;
    logic       rs1_en;
    logic       rs2_en;
    logic       is_bne;
    logic       mngr_rd;
    logic       mngr_wr;
    dmem_type_e dmem;
  } ref_info_t;

  logic        clk, reset;
  inst_t       inst_d;
  reg_addr_t   rd_d;
  logic        br_cond_eq_x;
  logic        imem_req_val, imem_req_rdy, imem_resp_val, imem_resp_rdy, imem_resp_drop;
  logic        dmem_req_val, dmem_req_rdy, dmem_resp_val, dmem_resp_rdy;
  logic        mngr2proc_val, mngr2proc_rdy, proc2mngr_val, proc2mngr_rdy;
  dpath_ctrl_t ctrl;
  logic        commit;

  // test data and the instruction memory built from it
  logic [31:0] tdata [0:1023];
  inst_t       imem [0:MEM-1];
  logic        taken [0:MEM-1];
  int          target [0:MEM-1];
  int          prog_len, mngr_len, limit, seed;

  // expected streams from the program walk
  reg_addr_t   exp_wb [0:MEM-1];
  dmem_type_e  exp_dm [0:MEM-1];
  int          dep [0:MEM-1];
  logic        path_wen [0:MEM-1];
  reg_addr_t   path_rd [0:MEM-1];
  int          path_len, wb_len, dm_len, p2m_exp, m2p_exp, drop_exp;

  // observed side
  int          commit_cyc [0:MEM-1];
  int          commit_cnt, wb_cnt, dm_cnt, p2m_cnt, m2p_cnt, drop_cnt, cycle;
  int          mismatches, others;

  // model state
  int          seq_idx, f_idx, d_idx, x_idx, dmem_pending, mngr_ptr;
  logic        imem_pending;

  tb_clock_gen clock_gen (.clk(clk), .reset(reset));

  proc_ctrl_top UUT (
    .clk(clk), .reset(reset), .inst_d(inst_d), .rd_d(rd_d), .br_cond_eq_x(br_cond_eq_x),
    .imem_req_val(imem_req_val), .imem_req_rdy(imem_req_rdy),
    .imem_resp_val(imem_resp_val), .imem_resp_rdy(imem_resp_rdy),
    .imem_resp_drop(imem_resp_drop),
    .dmem_req_val(dmem_req_val), .dmem_req_rdy(dmem_req_rdy),
    .dmem_resp_val(dmem_resp_val), .dmem_resp_rdy(dmem_resp_rdy),
    .mngr2proc_val(mngr2proc_val), .mngr2proc_rdy(mngr2proc_rdy),
    .proc2mngr_val(proc2mngr_val), .proc2mngr_rdy(proc2mngr_rdy),
    .ctrl(ctrl), .commit(commit)
  );

  function automatic logic coin_flip();
    int r;
    r = $random(seed);
    return r[0];
  endfunction

  // instruction classes straight from the ISA encodings
  function automatic ref_info_t classify(input inst_t w);
    ref_info_t   r;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [11:0] csr;
    r   = '0;
    f3  = w[14:12];
    f7  = w[31:25];
    csr = w[31:20];
    case (w[6:0])
      // alt funct7 only for sub and sra
      `OPC_OP:
        if (f7 == `F7_BASE || (f7 == `F7_ALT && (f3 == `F3_ADD_SUB || f3 == `F3_SRL_SRA)))
          r = {4'b1111, 3'b000, dmem_none};
      `OPC_LOAD:
        if (f3 == `F3_LW)
          r = {4'b1110, 3'b000, dmem_load};
      `OPC_STORE:
        if (f3 == `F3_SW)
          r = {4'b1011, 3'b000, dmem_store};
      `OPC_BRANCH:
        if (f3 == `F3_BNE)
          r = {4'b1011, 3'b100, dmem_none};
      `OPC_SYSTEM:
        if (f3 == `F3_CSRRS)
          r = {4'b1100, 1'b0, csr == `CSR_MNGR2PROC, 1'b0, dmem_none};
        else if (f3 == `F3_CSRRW)
          r = {4'b1010, 2'b00, csr == `CSR_PROC2MNGR, dmem_none};
      default:
        r = '0;
    endcase
    return r;
  endfunction

  // walk the program in order, following taken branches
  task automatic build_expected();
    ref_info_t info;
    inst_t     w;
    reg_addr_t rs1, rs2;
    int        idx, j, latest, steps;
    idx = 0;
    for (steps = 0; steps < MEM && idx < prog_len; steps++) begin
      w    = imem[idx];
      info = classify(w);
      rs1  = w[19:15];
      rs2  = w[24:20];
      if (info.legal) begin
        // latest older writer of any source, x0 excluded
        latest = -1;
        for (j = path_len - 1; j >= 0 && latest < 0; j--) begin
          if (path_wen[j] && path_rd[j] != '0
              && ((info.rs1_en && path_rd[j] == rs1) || (info.rs2_en && path_rd[j] == rs2)))
            latest = j;
        end
        dep[path_len]      = latest;
        path_wen[path_len] = info.wen;
        path_rd[path_len]  = w[11:7];
        path_len++;
        if (info.wen) begin
          exp_wb[wb_len] = w[11:7];
          wb_len++;
        end
        if (info.dmem != dmem_none) begin
          exp_dm[dm_len] = info.dmem;
          dm_len++;
        end
        m2p_exp += info.mngr_rd;
        p2m_exp += info.mngr_wr;
        // each taken bne squashes the fetch in flight once
        if (info.is_bne && taken[idx])
          drop_exp++;
      end
      idx = (info.legal && info.is_bne && taken[idx]) ? target[idx] : idx + 1;
    end
  endtask

  task automatic check_waddr(input string name, input reg_addr_t expected, input reg_addr_t actual);
    if (actual !== expected) begin
      mismatches++;
      $display("Fail %s: expected 0x%h, got 0x%h", name, expected, actual);
    end
  endtask

  task automatic check_dmem(input string name, input dmem_type_e expected, input dmem_type_e actual);
    if (actual !== expected) begin
      mismatches++;
      $display("Fail %s: expected 0x%h, got 0x%h", name, expected, actual);
    end
  endtask

  task automatic check_count(input string name, input int expected, input int actual);
    if (actual != expected) begin
      mismatches++;
      $display("Fail %s: expected 0x%h, got 0x%h", name, expected, actual);
    end
  endtask

  //--------------------------------------------------
  // input drive, 2 ns after each rising edge
  //--------------------------------------------------
  always @(posedge clk) begin
    #2;
    inst_d        = imem[d_idx];
    rd_d          = imem[d_idx][11:7];
    // bne is taken when the operands differ
    br_cond_eq_x  = !taken[x_idx];
    imem_resp_val = imem_pending;
    dmem_req_rdy  = coin_flip();
    dmem_resp_val = coin_flip() && (dmem_pending > 0);
    mngr2proc_val = coin_flip() && (mngr_ptr < mngr_len);
    proc2mngr_rdy = coin_flip();
  end

  //--------------------------------------------------
  // memory models and checks at the edge
  //--------------------------------------------------
  always @(posedge clk) begin : model
    int next_pc;
    cycle = cycle + 1;
    if (reset) begin
      seq_idx      <= 0;
      f_idx        <= 0;
      d_idx        <= 0;
      x_idx        <= 0;
      imem_pending <= 1'b0;
      dmem_pending = 0;
      mngr_ptr     = 0;
    end else begin
      // accepted request answers next cycle, redirect comes from the bne in X
      if (imem_req_val && imem_req_rdy) begin
        next_pc = (ctrl.pc_sel_f == `PC_SEL_BRANCH) ? target[x_idx] : seq_idx;
        if (next_pc > MEM - 1)
          next_pc = MEM - 1;
        f_idx        <= next_pc;
        seq_idx      <= next_pc + 1;
        imem_pending <= 1'b1;
      end else if (imem_resp_val && imem_resp_rdy) begin
        imem_pending <= 1'b0;
      end
      // response thrown away while F is squashed
      if (imem_resp_drop)
        drop_cnt++;
      // datapath pipeline registers for the fetch index
      if (ctrl.reg_en_d)
        d_idx <= f_idx;
      if (ctrl.reg_en_x)
        x_idx <= d_idx;

      if (dmem_req_val && !dmem_req_rdy) begin
        others++;
        $display("dmem request raised while memory was not ready at cycle %0d", cycle);
      end
      if (dmem_req_val && dmem_req_rdy) begin
        if (dm_cnt < dm_len) begin
          check_dmem("dmem_type_x", exp_dm[dm_cnt], ctrl.dmem_type_x);
        end else begin
          others++;
          $display("extra dmem request at cycle %0d", cycle);
        end
        dm_cnt++;
        dmem_pending++;
      end
      if (dmem_resp_val && dmem_resp_rdy)
        dmem_pending--;

      if (mngr2proc_val && mngr2proc_rdy) begin
        mngr_ptr++;
        m2p_cnt++;
      end
      if (proc2mngr_val && proc2mngr_rdy)
        p2m_cnt++;

      if (ctrl.rf_wen_w) begin
        if (wb_cnt < wb_len) begin
          check_waddr("rf_waddr_w", exp_wb[wb_cnt], ctrl.rf_waddr_w);
        end else begin
          others++;
          $display("unexpected register write to x%0d at cycle %0d", ctrl.rf_waddr_w, cycle);
        end
        wb_cnt++;
      end

      // no bypass, so a reader lands four or more cycles behind its writer
      if (commit) begin
        if (commit_cnt >= path_len) begin
          others++;
          $display("commit at cycle %0d beyond the end of the program path", cycle);
        end else begin
          commit_cyc[commit_cnt] = cycle;
          if (dep[commit_cnt] >= 0 && cycle - commit_cyc[dep[commit_cnt]] < 4) begin
            others++;
            $display("path entry %0d committed only %0d cycles after its producer",
                     commit_cnt, cycle - commit_cyc[dep[commit_cnt]]);
          end
        end
        commit_cnt++;
      end
    end
  end

  //--------------------------------------------------
  // test sequence
  //--------------------------------------------------
  initial begin
    int a;
    seed          = 32'h444d0524;
    inst_d        = '0;
    rd_d          = '0;
    br_cond_eq_x  = 1'b1;
    imem_req_rdy  = 1'b1;
    imem_resp_val = 1'b0;
    dmem_req_rdy  = 1'b0;
    dmem_resp_val = 1'b0;
    mngr2proc_val = 1'b0;
    proc2mngr_rdy = 1'b0;
    // unused words hold illegal opcodes tagged with their address
    for (a = 0; a < MEM; a++) begin
      imem[a]   = {a[24:0], 7'h7f};
      taken[a]  = 1'b0;
      target[a] = 0;
    end
    $readmemh("testbench/proc_ctrl_testdata.txt", tdata);
    if ($isunknown(tdata[0]) || tdata[0] == 0 || tdata[0] > MEM) begin
      others++;
      $display("test data file missing or malformed");
    end else begin
      prog_len = tdata[0];
      mngr_len = tdata[1];
    end
    // three words per program line after the two header words
    for (a = 0; a < prog_len; a++) begin
      imem[a]   = tdata[2 + 3 * a];
      taken[a]  = tdata[3 + 3 * a][0];
      target[a] = tdata[4 + 3 * a];
    end
    build_expected();
    limit = 40 * prog_len + 200;

    wait (reset === 1'b0);
    while (commit_cnt < path_len && cycle < limit)
      @(negedge clk);
    if (cycle >= limit) begin
      others++;
      $display("timeout after %0d cycles, %0d of %0d instructions committed",
               cycle, commit_cnt, path_len);
    end else begin
      // let the tail drain so stray commits show up
      repeat (20) @(negedge clk);
    end

    check_count("commit_count", path_len, commit_cnt);
    check_count("rf_wen_w_count", wb_len, wb_cnt);
    check_count("dmem_req_count", dm_len, dm_cnt);
    check_count("proc2mngr_count", p2m_exp, p2m_cnt);
    check_count("mngr2proc_count", m2p_exp, m2p_cnt);
    check_count("imem_resp_drop_count", drop_exp, drop_cnt);

    $display("errors: %0d value mismatches, %0d other failures", mismatches, others);
    if (mismatches == 0 && others == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule

// File: build.f
+incdir+design
design/proc_ctrl_pkg.sv
design/ctrl_decode.sv
design/ctrl_hazard.sv
design/ctrl_pipeline.sv
design/proc_ctrl_top.sv
testbench/tb_clock_gen.sv
testbench/proc_ctrl_tb.sv

// File: testbench/proc_ctrl_testdata.txt
// header: program length, manager data count (hex)
// program lines: instruction word, bne taken flag, branch target index
16 02
00012083 0 00 // lw   x1, 0(x2)
001081b3 0 00 // add  x3, x1, x1
00312223 0 00 // sw   x3, 4(x2)
fc002273 0 00 // csrr x4, mngr2proc
403202b3 0 00 // sub  x5, x4, x3
7c029073 0 00 // csrw proc2mngr, x5
00029663 1 09 // bne  x5, x0, taken to 9
00108333 0 00 // add  x6, x1, x1 (squashed)
0010e3b3 0 00 // or   x7, x1, x1 (squashed)
0030c433 0 00 // xor  x8, x1, x3
001424b3 0 00 // slt  x9, x8, x1
0020b533 0 00 // sltu x10, x1, x2
00209463 0 0e // bne  x1, x2, not taken
009575b3 0 00 // and  x11, x10, x9
4015d633 0 00 // sra  x12, x11, x1
003156b3 0 00 // srl  x13, x2, x3
00d69733 0 00 // sll  x14, x13, x13
00872783 0 00 // lw   x15, 8(x14)
fc002873 0 00 // csrr x16, mngr2proc
7c081073 0 00 // csrw proc2mngr, x16
00f82623 0 00 // sw   x15, 12(x16)
ffffffff 0 00 // illegal word
// manager input data, one word per csrr
0000abcd
12345678
